// File: hw/shiftPkg.sv
// Shared types for the pipelined barrel shifter

package shiftPkg;

  // Width of the shifted word
  parameter int DataWidth = 32;

  // Width of the shift amount
  // One bit per stage, stage k moves by 2**k
  parameter int AmountWidth = 5;

  // Operation select, two bits
  // Left-going ops share the low half of the code space
  typedef enum logic [1:0] {
    // Rotate left, top bits wrap to the bottom
    OpRotL = 2'b00,
    // Shift left, zero fill from the bottom
    OpShl  = 2'b01,
    // Shift right, fill with copies of bit 31
    OpSra  = 2'b10,
    // Shift right, zero fill from the top
    OpSrl  = 2'b11
  } shiftOp_e;

  // One shift request, 39 bits in total
  // Travels from the input through every stage and both registers
  // Amount and op ride along so later stages can still decode them
  typedef struct packed {
    // Word being shifted, partially shifted between stages
    logic [DataWidth-1:0]   data;
    // Full shift amount, each stage looks at its own bit
    logic [AmountWidth-1:0] amount;
    // Operation, constant for the life of the request
    shiftOp_e               op;
  } shiftReq_t;

endpackage

// File: hw/shiftStage.sv
`timescale 1ns/1ps

// One conditional stage of the barrel shifter
// Moves the word by Dist positions when its amount bit is set
// Otherwise the word passes unchanged
module shiftStage #(
  // Shift distance, power of two below DataWidth
  parameter int Dist = 16
) (
  input  shiftPkg::shiftReq_t in,
  output shiftPkg::shiftReq_t out
);

  // Amount bit that belongs to this distance
  localparam int AmtBit = $clog2(Dist);

  // Index of the sign bit
  localparam int Msb = shiftPkg::DataWidth - 1;

  // Elaboration checks on the distance
  if ((Dist < 1) || ((Dist & (Dist - 1)) != 0)) begin : gBadDist
    $error("shiftStage: Dist %0d is not a power of two", Dist);
  end

  if (Dist >= shiftPkg::DataWidth) begin : gDistTooWide
    $error("shiftStage: Dist %0d not below DataWidth", Dist);
  end

  if (AmtBit >= shiftPkg::AmountWidth) begin : gNoAmountBit
    $error("shiftStage: no amount bit for Dist %0d", Dist);
  end

  // Word after the move, used only when the stage is selected
  logic [shiftPkg::DataWidth-1:0] shifted;

  // Stage select from the amount
  logic sel;

  // Fill bit for right shifts
  logic rightFill;

  assign sel = in.amount[AmtBit];

  // Sign copy for arithmetic, zero for logical
  assign rightFill = (in.op == shiftPkg::OpSra) ? in.data[Msb] : 1'b0;

  always_comb begin
    shifted = in.data;
    case (in.op)
      shiftPkg::OpRotL: begin
        // Top Dist bits wrap around to the bottom
        shifted = {in.data[Msb-Dist:0], in.data[Msb -: Dist]};
      end
      shiftPkg::OpShl: begin
        // Low end filled with zeros
        shifted = {in.data[Msb-Dist:0], {Dist{1'b0}}};
      end
      shiftPkg::OpSra,
      shiftPkg::OpSrl: begin
        // Sign or zero fill from the top
        shifted = {{Dist{rightFill}}, in.data[Msb:Dist]};
      end
      default: begin
        shifted = in.data;
      end
    endcase
  end

  // Data mux, selected stage takes the moved word
  assign out.data = sel ? shifted : in.data;

  // Amount and op untouched for the following stages
  assign out.amount = in.amount;
  assign out.op     = in.op;

endmodule

// File: hw/shiftPipeReg.sv
`timescale 1ns/1ps

// One-entry valid/ready register slice for shift requests
// Loads on an accepted input, holds under back-pressure
// Full throughput since ready looks through to downstream
module shiftPipeReg (
  input  logic                clk,
  input  logic                rst,

  // Upstream side
  input  shiftPkg::shiftReq_t inReq,
  input  logic                inValid,
  output logic                inReady,

  // Downstream side
  output shiftPkg::shiftReq_t outReq,
  output logic                outValid,
  input  logic                outReady
);

  // Held request payload
  shiftPkg::shiftReq_t reqQ;

  // Occupancy flag
  logic validQ;

  // Accept handshake on the input side
  logic load;

  // Ready when the slot is empty or the held entry leaves this cycle
  assign inReady = !validQ || outReady;

  assign load = inValid && inReady;

  // Valid tracks occupancy
  // Slot is free whenever inReady is high, so the new valid is just inValid
  always_ff @(posedge clk) begin
    if (rst) begin
      validQ <= 1'b0;
    end else if (inReady) begin
      validQ <= inValid;
    end
  end

  // Payload captured only on a real accept
  always_ff @(posedge clk) begin
    if (load) begin
      reqQ <= inReq;
    end
  end

  assign outReq   = reqQ;
  assign outValid = validQ;

  // Stalled entry must not move or vanish
  aHoldOnStall: assert property (
    @(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outReq))
  ) else begin
    $error("shiftPipeReg: output changed while stalled");
  end

  // Slice comes out of reset empty
  aEmptyAfterReset: assert property (
    @(posedge clk)
    rst |=> !outValid
  ) else begin
    $error("shiftPipeReg: outValid high after reset");
  end

endmodule

// File: hw/shiftUnit.sv
`timescale 1ns/1ps

// Pipelined 32-bit barrel shifter
// Five conditional stages, distances 1 2 4 8 16
// Register A after stage SplitAt, register B after the last stage
// Two cycle latency, one result per cycle
module shiftUnit #(
  // Number of stages ahead of register A, 1 to 4
  parameter int SplitAt = 3
) (
  input  logic                          clk,
  input  logic                          rst,

  // Request side
  input  shiftPkg::shiftReq_t           inReq,
  input  logic                          inValid,
  output logic                          inReady,

  // Result side, data field only
  output logic [shiftPkg::DataWidth-1:0] outData,
  output logic                          outValid,
  input  logic                          outReady
);

  // One stage per amount bit
  localparam int NumStages = shiftPkg::AmountWidth;

  // Both registers need at least one stage on each side
  if ((SplitAt < 1) || (SplitAt > NumStages - 1)) begin : gBadSplit
    $error("shiftUnit: SplitAt %0d out of range", SplitAt);
  end

  // Stage inputs and outputs, index k has distance 2**k
  shiftPkg::shiftReq_t stageIn  [NumStages];
  shiftPkg::shiftReq_t stageOut [NumStages];

  // Register A outputs
  shiftPkg::shiftReq_t regAReq;
  logic                regAValid;

  // Register B input ready, seen by register A
  logic                regBReady;

  // Register B held request
  shiftPkg::shiftReq_t regBReq;

  // Stage chain
  for (genvar k = 0; k < NumStages; k++) begin : gStage
    // First stage fed from the port
    if (k == 0) begin : gFromPort
      assign stageIn[k] = inReq;
    // First stage after the split fed from register A
    end else if (k == SplitAt) begin : gFromRegA
      assign stageIn[k] = regAReq;
    // Everything else chains straight through
    end else begin : gFromPrev
      assign stageIn[k] = stageOut[k-1];
    end

    shiftStage #(
      .Dist (1 << k)
    ) u_shiftStage (
      .in  (stageIn[k]),
      .out (stageOut[k])
    );
  end

  // Register A, closes the front half
  // Its ready is the unit's input ready
  shiftPipeReg u_regA (
    .clk      (clk),
    .rst      (rst),
    .inReq    (stageOut[SplitAt-1]),
    .inValid  (inValid),
    .inReady  (inReady),
    .outReq   (regAReq),
    .outValid (regAValid),
    .outReady (regBReady)
  );

  // Register B, closes the back half and drives the outputs
  shiftPipeReg u_regB (
    .clk      (clk),
    .rst      (rst),
    .inReq    (stageOut[NumStages-1]),
    .inValid  (regAValid),
    .inReady  (regBReady),
    .outReq   (regBReq),
    .outValid (outValid),
    .outReady (outReady)
  );

  // Amount and op are dropped at the port
  assign outData = regBReq.data;

endmodule

// File: test/shiftModel.svh
`ifndef SHIFT_MODEL_SVH
`define SHIFT_MODEL_SVH

// Reference model and random source for shiftTb
// Included inside the testbench module body

// Fixed seed for every run
localparam logic [31:0] LfsrSeed = 32'h44e5baee;

// Galois mask for x^32 + x^30 + x^26 + x^25 + 1
localparam logic [31:0] LfsrTaps = 32'ha3000000;

logic [31:0] lfsrState = LfsrSeed;

// Accepted requests waiting for their result, oldest first
shiftPkg::shiftReq_t pendQ[$];

// Acceptance cycle of each pending request
int stampQ[$];

// One Galois step, returns the bit shifted out
function automatic logic lfsrStep();
  logic outBit;
  outBit = lfsrState[0];
  lfsrState = lfsrState >> 1;
  if (outBit) begin
    lfsrState = lfsrState ^ LfsrTaps;
  end
  return outBit;
endfunction

// n random bits, one step each, packed at the low end
function automatic logic [31:0] randBits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsrStep()};
  end
  return r;
endfunction

// Expected word straight from the operation rules
function automatic logic [shiftPkg::DataWidth-1:0] expectedResult(
  input shiftPkg::shiftReq_t req
);
  logic [shiftPkg::DataWidth-1:0]        d;
  logic signed [shiftPkg::DataWidth-1:0] sd;
  logic [shiftPkg::DataWidth-1:0]        r;
  int                                    a;
  d = req.data;
  sd = req.data;
  a = int'(req.amount);
  case (req.op)
    // Bits leaving the top come back in at the bottom
    shiftPkg::OpRotL: r = (a == 0) ? d : ((d << a) | (d >> (shiftPkg::DataWidth - a)));
    shiftPkg::OpShl:  r = d << a;
    // Sign copies from the top
    shiftPkg::OpSra:  r = sd >>> a;
    shiftPkg::OpSrl:  r = d >> a;
    default:          r = d;
  endcase
  return r;
endfunction

function automatic void pushPending(input shiftPkg::shiftReq_t req, input int stamp);
  pendQ.push_back(req);
  stampQ.push_back(stamp);
endfunction

function automatic void popPending(output shiftPkg::shiftReq_t req, output int stamp);
  req = pendQ.pop_front();
  stamp = stampQ.pop_front();
endfunction

`endif

// File: test/shiftTb.sv
`timescale 1ns/1ps

// Testbench for the pipelined barrel shifter
// Random requests checked against a reference model
module shiftTb;

  // Transaction counts per test
  localparam int OpsPerOp  = 100;
  localparam int ZeroPerOp = 4;
  localparam int BurstLen  = 8;
  localparam int BpTxn     = 100;
  localparam int TotalTxn  = 4 * OpsPerOp + 4 * ZeroPerOp + 1 + BurstLen + BpTxn;

  // Up to 8 cycles per request plus reset and drain slack
  localparam int TimeoutCycles = TotalTxn * 8 + 200;

  logic                           clk = 1'b0;
  logic                           rst;
  shiftPkg::shiftReq_t            inReq;
  logic                           inValid;
  logic                           inReady;
  logic [shiftPkg::DataWidth-1:0] outData;
  logic                           outValid;
  logic                           outReady;

  // Monitor state, written only at the rising edge
  int cycle = 0;
  int acceptCount = 0;
  int outCount = 0;
  int lastLatency = 0;
  int outCycles[$];

  // Check bookkeeping
  int checks = 0;
  int errors = 0;
  int checksMark = 0;
  int errorsMark = 0;

  // Random outReady while set
  logic randomReady = 1'b0;

  `include "shiftModel.svh"

  shiftUnit #(
    .SplitAt (3)
  ) u_shiftUnit (
    .clk      (clk),
    .rst      (rst),
    .inReq    (inReq),
    .inValid  (inValid),
    .inReady  (inReady),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady)
  );

  initial begin
    forever begin
      #5 clk = ~clk;
    end
  end

  // Handshake monitor and scoreboard
  always @(posedge clk) begin : monitor
    shiftPkg::shiftReq_t            req;
    logic [shiftPkg::DataWidth-1:0] expData;
    int                             stamp;
    cycle++;
    if (!rst) begin
      // Pop before push since a same-edge accept is always younger
      if (outValid && outReady) begin
        checks++;
        assert (pendQ.size() > 0) else begin
          $display("%0t: a result left with no request pending", $time);
          errors++;
        end
        if (pendQ.size() > 0) begin
          popPending(req, stamp);
          expData = expectedResult(req);
          checks++;
          assert (outData === expData) else begin
            $display("mismatch at %0t: op %s amount %0d data %h got %h expected %h",
                     $time, req.op.name(), req.amount, req.data, outData, expData);
            errors++;
          end
          lastLatency = cycle - stamp;
        end
        outCycles.push_back(cycle);
        outCount++;
      end
      if (inValid && inReady) begin
        pushPending(inReq, cycle);
        acceptCount++;
      end
    end
  end

  // Ends a hung run
  initial begin
    while (cycle < TimeoutCycles) begin
      @(negedge clk);
    end
    $display("timeout after %0d cycles before all tests finished", cycle);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // New outReady at each falling edge while back-pressure is on
  task automatic nextCycle();
    @(negedge clk);
    if (randomReady) begin
      outReady = lfsrStep();
    end
  endtask

  // Holds the request until it is taken
  task automatic sendReq(input shiftPkg::shiftReq_t req);
    int target;
    target = acceptCount + 1;
    inReq = req;
    inValid = 1'b1;
    do begin
      nextCycle();
    end while (acceptCount < target);
  endtask

  task automatic drain();
    inValid = 1'b0;
    while (outCount < acceptCount) begin
      nextCycle();
    end
  endtask

  function automatic shiftPkg::shiftReq_t randomReq(input int op);
    shiftPkg::shiftReq_t req;
    logic [31:0]         bits;
    req.data = randBits(shiftPkg::DataWidth);
    bits = randBits(shiftPkg::AmountWidth);
    req.amount = bits[shiftPkg::AmountWidth-1:0];
    req.op = shiftPkg::shiftOp_e'(op[1:0]);
    return req;
  endfunction

  task automatic reportTest(input string name);
    $display("test %-14s checks %0d errors %0d", name, checks - checksMark,
             errors - errorsMark);
    checksMark = checks;
    errorsMark = errors;
  endtask

  initial begin
    shiftPkg::shiftReq_t req;
    int                  span;
    rst = 1'b1;
    inValid = 1'b0;
    inReq = '0;
    outReady = 1'b0;

    // Both slices empty during and after reset
    repeat (5) begin
      @(negedge clk);
      checks++;
      assert (!outValid && inReady) else begin
        $display("mismatch at %0t: outValid %b inReady %b during reset, expected 0 and 1",
                 $time, outValid, inReady);
        errors++;
      end
    end
    rst = 1'b0;
    nextCycle();
    checks++;
    assert (!outValid && inReady) else begin
      $display("mismatch at %0t: outValid %b inReady %b after reset, expected 0 and 1",
               $time, outValid, inReady);
      errors++;
    end
    reportTest("reset");

    // Every op over random words and amounts
    outReady = 1'b1;
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < OpsPerOp; i++) begin
        req = randomReq(op);
        // Negative word on every other arithmetic shift
        if ((req.op == shiftPkg::OpSra) && (i % 2 == 0)) begin
          req.data[shiftPkg::DataWidth-1] = 1'b1;
        end
        sendReq(req);
      end
    end
    drain();
    reportTest("random ops");

    // Zero amount passes the word through
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < ZeroPerOp; i++) begin
        req = randomReq(op);
        req.amount = '0;
        sendReq(req);
      end
    end
    drain();
    reportTest("zero amount");

    // Isolated request into an empty pipe
    sendReq(randomReq(1));
    drain();
    checks++;
    assert (lastLatency == 2) else begin
      $display("mismatch at %0t: latency %0d cycles, expected 2", $time, lastLatency);
      errors++;
    end
    for (int i = 0; i < BurstLen; i++) begin
      sendReq(randomReq(i % 4));
    end
    drain();
    span = outCycles[outCycles.size()-1] - outCycles[outCycles.size()-BurstLen];
    checks++;
    assert (span == BurstLen - 1) else begin
      $display("mismatch at %0t: burst of %0d results took %0d cycles, expected %0d",
               $time, BurstLen, span + 1, BurstLen);
      errors++;
    end
    reportTest("latency");

    // Random gaps upstream and random stalls downstream
    randomReady = 1'b1;
    for (int i = 0; i < BpTxn; i++) begin
      if (!lfsrStep()) begin
        inValid = 1'b0;
        nextCycle();
      end
      sendReq(randomReq(int'(randBits(2))));
    end
    drain();
    randomReady = 1'b0;
    outReady = 1'b1;
    checks++;
    assert ((pendQ.size() == 0) && (outCount == acceptCount)) else begin
      $display("%0t: %0d requests still pending, %0d results for %0d accepted requests",
               $time, pendQ.size(), outCount, acceptCount);
      errors++;
    end
    reportTest("back-pressure");

    $display("total checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+test
hw/shiftPkg.sv
hw/shiftStage.sv
hw/shiftPipeReg.sv
hw/shiftUnit.sv
test/shiftTb.sv

// File: Makefile
# Verilator build and run for the pipelined barrel shifter
# Any variable can be overridden, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= shiftTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

SRCS := hw/shiftPkg.sv \
        hw/shiftStage.sv \
        hw/shiftPipeReg.sv \
        hw/shiftUnit.sv \
        test/shiftModel.svh \
        test/shiftTb.sv

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$($(EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
